// File: build.f
design/armIsaPkg.sv
design/uopCtrlPkg.sv
design/uopIfs.sv
design/instrClassifier.sv
design/regListTracker.sv
design/uopSequencer.sv
design/microOpExpander.sv
sim/microOpChecks_sva.sv
sim/tbMicroOp.sv

// File: run.sh
#!/bin/sh
# Build and run the micro-op expander testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tbMicroOp -f build.f -o simMicroOp

./obj_dir/simMicroOp +verilator+error+limit+100 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
	echo "Simulation did not reach its end"
	exit 1
fi
echo "Simulation passed"

// File: sim/microOpCases.txt
// Per case: instruction, flags (NZCV), micro-op count, then per micro-op its word and control
// Control nibbles from the top: instrMux noFlagUpdate uopStall ldmForward prevRsr keepV 0 Rz
10 // Number of cases
E0821003 0 1 E0821003 00000000 // ADD r1, r2, r3
E3A00005 0 1 E3A00005 00000000 // MOV r0, #5
E0821413 0 2 E1A0F413 1110000C E082100F 10001002 // ADD r1, r2, r3, LSL r4
E0565857 0 2 E1A0F857 1110000C E056500F 10001002 // SUBS r5, r6, r7, ASR r8
E0214392 0 2 E00F0392 1010010C E08F1004 10000001 // MLA r1, r2, r3, r4
00358796 0 2 000F0796 1010010C 009F5008 10000001 // MLASEQ expands whatever the flags
E0A21493 0 2 E08F1493 1010010C E0A21192 10000000 // UMLAL r1, r2, r3, r4
EB000010 0 2 E1A0E00F 10100000 EA000010 10000000 // BL forward
E890002A 0 3 E5901000 11100000 E5903004 11110000 E5905008 11010000 // LDMIA r0, {r1,r3,r5}
E8120091 0 3 E5120008 11100000 E5124004 11110000 E5127000 11010000 // LDMDA r2, {r0,r4,r7}
E9130044 0 2 E5132008 11100000 E5136004 11010000 // LDMDB r3, {r2,r6}
E9940200 0 1 E5949004 11000000 // LDMIB r4, {r9}
08900006 0 1 08900006 00000000 // LDMEQ with Z clear passes through
08900002 4 1 05901000 11000000 // LDMEQ with Z set
E8900000 0 1 E8900000 00000000 // LDM with empty list
E8800006 0 1 E8800006 00000000 // STMIA is not expanded

// File: sim/tbMicroOp.sv
// Micro-op expander testbench
`timescale 1ns/10ps

module tbMicroOp
	import armIsaPkg::*;
	import uopCtrlPkg::*;
();

	localparam int caseCycleLimit = 40; // Most cycles one case may take

	logic clk = 1'b0;
	logic reset = 1'b1; // Held through the first 5 edges
	armInstr_t defaultInstr = '0;
	logic stallUop = 1'b0;
	armFlags_t flags = '0;
	logic instrMux, noFlagUpdate, uopStall, ldmForward, prevRsr, keepV;
	rzSel_t regFileRz;
	armInstr_t uopInstr;

	logic [31:0] caseMem [0:255]; // Flat word stream from the cases file
	armInstr_t curInstr = '0; // Instruction under test shown in error lines
	int curUop = 0; // Micro-op index within the case

	microOpExpander u_dut (
		.clk(clk),
		.reset(reset),
		.defaultInstr(defaultInstr),
		.stallUop(stallUop),
		.flags(flags),
		.instrMux(instrMux),
		.noFlagUpdate(noFlagUpdate),
		.uopStall(uopStall),
		.ldmForward(ldmForward),
		.prevRsr(prevRsr),
		.keepV(keepV),
		.regFileRz(regFileRz),
		.uopInstr(uopInstr)
	);

	bind microOpExpander microOpChecks checks (
		.clk(clk),
		.reset(reset),
		.stallUop(stallUop),
		.instrMux(instrMux),
		.uopStall(uopStall),
		.uopInstr(uopInstr)
	);

	always #5 clk = ~clk; // 10 ns period

	function automatic logic randomStall();
		return ($urandom % 4) == 0; // Back-pressure about one cycle in four
	endfunction

	task automatic abortRun();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkUop(input string name, input armInstr_t got, input armInstr_t exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h (instr %h, uop %0d)",
				name, got, exp, curInstr, curUop);
			abortRun();
		end
	endtask

	task automatic checkRz(input string name, input rzSel_t got, input rzSel_t exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h (instr %h, uop %0d)",
				name, got, exp, curInstr, curUop);
			abortRun();
		end
	endtask

	task automatic checkStrobe(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h (instr %h, uop %0d)",
				name, got, exp, curInstr, curUop);
			abortRun();
		end
	endtask

	// Bound assertion failure ends the run
	always @(posedge clk) begin
		if (u_dut.checks.assertFails != 0) begin
			$display("A bound assertion on the expander failed at %0t", $time);
			abortRun();
		end
	end

	// Control word holds one flag per nibble and Rz in the low nibble
	task automatic compareOutputs(input armInstr_t expUop, input logic [31:0] expCtrl);
		checkUop("uopInstr", uopInstr, expUop);
		checkRz("regFileRz", regFileRz, rzSel_t'(expCtrl[3:0]));
		checkStrobe("instrMux", instrMux, expCtrl[28]);
		checkStrobe("noFlagUpdate", noFlagUpdate, expCtrl[24]);
		checkStrobe("uopStall", uopStall, expCtrl[20]);
		checkStrobe("ldmForward", ldmForward, expCtrl[16]);
		checkStrobe("prevRsr", prevRsr, expCtrl[12]);
		checkStrobe("keepV", keepV, expCtrl[8]);
	endtask

	// Walks one expansion until its last micro-op is accepted
	task automatic runCase(input int base, input int nWords);
		int cycles;
		int idx;
		logic accepted;
		logic finished;
		cycles = 0;
		idx = 0;
		finished = 1'b0;
		while (!finished) begin
			@(negedge clk); // Outputs settled mid-cycle
			curUop = idx;
			compareOutputs(caseMem[base + 2 * idx], caseMem[base + 2 * idx + 1]);
			accepted = !stallUop; // Micro-op taken at the coming edge
			if (accepted && !uopStall) begin
				finished = 1'b1; // Sequence ends here
			end else if (accepted && idx + 1 >= nWords) begin
				$display("Instruction %h gave more micro-ops than the %0d expected",
					curInstr, nWords);
				abortRun();
			end
			cycles++;
			if (cycles > caseCycleLimit) begin
				$display("Timeout: instruction %h still expanding after %0d cycles",
					curInstr, cycles);
				abortRun();
			end
			@(posedge clk);
			if (!finished) begin
				stallUop <= randomStall();
				if (accepted) idx++;
			end
		end
	endtask

	initial begin
		int pos;
		int nCases;
		int nWords;
		void'($urandom(32'ha0e)); // Seed once
		$readmemh("sim/microOpCases.txt", caseMem);
		nCases = int'(caseMem[0]);
		pos = 1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int c = 0; c < nCases; c++) begin
			nWords = int'(caseMem[pos + 2]);
			curInstr = caseMem[pos];
			defaultInstr <= caseMem[pos]; // Held until the sequence ends
			flags <= armFlags_t'(caseMem[pos + 1][3:0]);
			stallUop <= randomStall();
			runCase(pos + 3, nWords);
			pos += 3 + 2 * nWords;
		end
		defaultInstr <= '0;
		stallUop <= 1'b0;
		@(posedge clk); // Last assertion sample
		if (u_dut.checks.assertFails == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("%0d assertion failures in the bound checks", u_dut.checks.assertFails);
			abortRun();
		end
	end

endmodule

// File: sim/microOpChecks_sva.sv
// Expander sequencing assertions
`timescale 1ns/10ps

module microOpChecks
	import armIsaPkg::*;
(
	input logic clk,
	input logic reset,
	input logic stallUop,
	input logic instrMux,
	input logic uopStall,
	input armInstr_t uopInstr
);

	int assertFails = 0; // Failures seen so far

	// Reset leaves no sequence open
	stallInReset: assert property (@(posedge clk) reset |-> !uopStall)
		else begin
			$error("uopStall high during reset");
			assertFails++;
		end

	stallNeedsMux: assert property (@(posedge clk) disable iff (reset) uopStall |-> instrMux)
		else begin
			$error("uopStall high without instrMux");
			assertFails++;
		end

	// Back-pressure repeats the same micro-op
	holdOnStall: assert property (@(posedge clk) disable iff (reset)
		stallUop |=> $stable(uopInstr))
		else begin
			$error("uopInstr changed while stallUop was high");
			assertFails++;
		end

endmodule

// File: design/microOpExpander.sv
// Micro-op expander top
`timescale 1ns/10ps

module microOpExpander
	import armIsaPkg::*;
	import uopCtrlPkg::*;
(
	input logic clk,
	input logic reset,
	input armInstr_t defaultInstr, // Held by the pipeline while uopStall
	input logic stallUop, // Downstream back-pressure
	input armFlags_t flags,
	output logic instrMux,
	output logic noFlagUpdate,
	output logic uopStall,
	output logic ldmForward,
	output logic prevRsr,
	output logic keepV,
	output rzSel_t regFileRz,
	output armInstr_t uopInstr
);

	decodeIf decBus(); // Classifier to tracker and FSM
	ldmIf ldmBus(); // Tracker and FSM

	instrClassifier classifier (
		.dec(decBus.src),
		.instr(defaultInstr),
		.flags(flags)
	);

	regListTracker tracker (
		.clk(clk),
		.reset(reset),
		.dec(decBus.dst),
		.ldm(ldmBus.src)
	);

	uopSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.stallUop(stallUop),
		.dec(decBus.dst),
		.ldm(ldmBus.dst),
		.instrMux(instrMux),
		.noFlagUpdate(noFlagUpdate),
		.uopStall(uopStall),
		.ldmForward(ldmForward),
		.prevRsr(prevRsr),
		.keepV(keepV),
		.regFileRz(regFileRz),
		.uopInstr(uopInstr)
	);

endmodule

// File: design/uopSequencer.sv
// Micro-op expansion FSM
`timescale 1ns/10ps

module uopSequencer
	import armIsaPkg::*;
	import uopCtrlPkg::*;
(
	input logic clk,
	input logic reset,
	input logic stallUop,
	decodeIf.dst dec,
	ldmIf.dst ldm,
	output logic instrMux,
	output logic noFlagUpdate,
	output logic uopStall,
	output logic ldmForward,
	output logic prevRsr,
	output logic keepV,
	output rzSel_t regFileRz,
	output armInstr_t uopInstr
);

	seqState_t state, nextState;
	uopCtrl_t ctrl;
	logic ldmGo; // Passing LDM with a non-empty list
	logic isLong; // Long multiply form
	logic wantTake;
	armInstr_t ldmUop, mlaFirst;
	armCond_t cond;

	assign cond = dec.instr[condHi:condLo];
	assign isLong = dec.instr[bitU];
	assign ldmGo = (dec.cls == clsLdm) && dec.condPass && (dec.listCount != '0);

	// Single I-type load, pre-indexed, no writeback
	assign ldmUop = {cond, lsSingleImm, 1'b1, dec.addUp, 1'b0, 1'b0, 1'b1,
		dec.instr[rnHi:rnLo], ldm.nextReg, ldm.curOffset};

	// Multiply into Rz with A and S cleared
	assign mlaFirst = {cond, 4'b0000, isLong, dec.instr[bitB], 2'b00, regRz,
		isLong ? dec.instr[rdHi:rdLo] : 4'b0000,
		dec.instr[rsHi:rsLo], mulMarker, dec.instr[3:0]};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stReady;
		end else if (!stallUop) begin // Back-pressure holds the state
			state <= nextState;
		end
	end

	always_comb begin
		nextState = stReady;
		ctrl = '0;
		regFileRz = rzNone;
		uopInstr = dec.instr; // Plain pass-through
		wantTake = 1'b0;
		case (state)
			stReady: begin
				case (dec.cls)
					clsRsr: begin // MOV Rz, shifter operand
						ctrl.instrMux = 1'b1;
						ctrl.noFlagUpdate = 1'b1;
						ctrl.uopStall = 1'b1;
						regFileRz = rzWrite;
						uopInstr = {dec.instr[condHi:classLo], dpMov, 1'b0, 4'b0000, regRz,
							dec.instr[rsHi:0]};
						nextState = stRsr;
					end
					clsMla: begin
						ctrl.instrMux = 1'b1;
						ctrl.uopStall = 1'b1;
						ctrl.keepV = 1'b1; // MUL leaves V alone
						regFileRz = rzWrite;
						uopInstr = mlaFirst;
						nextState = stMla;
					end
					clsBl: begin // MOV LR, PC
						ctrl.instrMux = 1'b1;
						ctrl.uopStall = 1'b1;
						uopInstr = {cond, 3'b000, dpMov, 1'b0, 4'b0000, regLink, 8'h00, regPc};
						nextState = stBl;
					end
					clsLdm: begin
						if (ldmGo) begin // Failing or empty falls through as plain
							ctrl.instrMux = 1'b1;
							ctrl.noFlagUpdate = 1'b1;
							ctrl.uopStall = !ldm.lastReg;
							wantTake = 1'b1;
							uopInstr = ldmUop;
							nextState = ldm.lastReg ? stReady : stLdm;
						end
					end
					default: ;
				endcase
			end
			stRsr: begin // Original op with Rz as unshifted operand
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				regFileRz = rzReadB;
				uopInstr = {dec.instr[condHi:rdLo], 8'h00, regRz};
			end
			stMla: begin
				ctrl.instrMux = 1'b1;
				if (isLong) begin // Accumulate into RdHi:RdLo
					uopInstr = {cond, 4'b0000, 1'b1, dec.instr[bitB], 1'b1, dec.instr[bitSL],
						dec.instr[rnHi:rnLo], dec.instr[rdHi:rdLo], dec.instr[rdHi:rdLo],
						mulMarker, dec.instr[rnHi:rnLo]};
				end else begin // ADD Rd, Rz, Rn keeping S
					regFileRz = rzReadA;
					uopInstr = {cond, 3'b000, dpAdd, dec.instr[bitSL], regRz,
						dec.instr[rnHi:rnLo], 8'h00, dec.instr[rdHi:rdLo]};
				end
			end
			stBl: begin // Plain branch, link bit cleared
				ctrl.instrMux = 1'b1;
				uopInstr = {dec.instr[condHi:classLo], 1'b0, dec.instr[bitU:0]};
			end
			stLdm: begin
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
				ctrl.ldmForward = 1'b1; // Base may come from a prior load
				ctrl.uopStall = !ldm.lastReg;
				wantTake = 1'b1;
				uopInstr = ldmUop;
				nextState = ldm.lastReg ? stReady : stLdm;
			end
			default: nextState = stReady;
		endcase
	end

	assign ldm.take = wantTake && !stallUop; // Tracker steps only on accepted transfers

	assign instrMux = ctrl.instrMux;
	assign noFlagUpdate = ctrl.noFlagUpdate;
	assign uopStall = ctrl.uopStall;
	assign ldmForward = ctrl.ldmForward;
	assign prevRsr = ctrl.prevRsr;
	assign keepV = ctrl.keepV;

endmodule

// File: design/regListTracker.sv
// LDM register list tracker
`timescale 1ns/10ps

module regListTracker
	import armIsaPkg::*;
	import uopCtrlPkg::*;
(
	input logic clk,
	input logic reset,
	decodeIf.dst dec,
	ldmIf.src ldm
);

	regList_t pendList; // Registers still to load
	ldmOffset_t pendOffset; // Offset of the next transfer
	logic active; // Sequence under way
	regList_t srcList, lowBit, nextList;
	ldmOffset_t srcOffset, stepOffset;
	armReg_t lowReg;

	// An empty list means no sequence, so the fresh list is shown
	assign active = |pendList;
	assign srcList = active ? pendList : dec.instr[listHi:0];
	assign srcOffset = active ? pendOffset : dec.startOffset;

	assign lowBit = srcList & (~srcList + 16'd1); // Isolate lowest set bit
	assign nextList = srcList & ~lowBit;

	always_comb begin
		lowReg = '0;
		for (int i = listHi; i >= 0; i--) begin // Lowest index wins
			if (srcList[i]) lowReg = armReg_t'(i);
		end
	end

	assign stepOffset = dec.addUp ? srcOffset + ldmOffset_t'(wordBytes)
		: srcOffset - ldmOffset_t'(wordBytes);

	assign ldm.nextReg = lowReg;
	assign ldm.lastReg = (srcList != '0) && (nextList == '0);
	assign ldm.curOffset = srcOffset;

	always_ff @(posedge clk) begin
		if (reset) begin
			pendList <= '0;
		end else if (ldm.take) begin
			pendList <= nextList; // Drop the register just sent
		end
	end

	always_ff @(posedge clk) begin
		if (ldm.take) begin
			pendOffset <= stepOffset;
		end
	end

endmodule

// File: design/instrClassifier.sv
// Instruction class decoder
`timescale 1ns/10ps

module instrClassifier
	import armIsaPkg::*;
	import uopCtrlPkg::*;
(
	decodeIf.src dec,
	input armInstr_t instr,
	input armFlags_t flags
);

	armCond_t cond;
	logic isRsr, isMla, isLdm, isBl;
	ldmOffset_t listBytes; // n * 4

	assign cond = instr[condHi:condLo];
	assign dec.instr = instr;

	// Class matches, in priority order below
	assign isRsr = (instr[classHi:classLo] == 3'b000) && !instr[mulHi] && instr[mulLo];
	assign isMla = (instr[classHi:bitP] == 4'b0000) && instr[bitA]
		&& (instr[mulHi:mulLo] == mulMarker);
	assign isLdm = (instr[classHi:classLo] == 3'b100) && instr[bitSL]; // Loads only
	assign isBl = ({instr[classHi:classLo], instr[bitP]} == 4'b1011);

	always_comb begin
		if (isRsr) dec.cls = clsRsr;
		else if (isMla) dec.cls = clsMla;
		else if (isLdm) dec.cls = clsLdm;
		else if (isBl) dec.cls = clsBl;
		else dec.cls = clsPlain;
	end

	always_comb begin
		case (cond)
			4'h0: dec.condPass = flags.z; // EQ
			4'h1: dec.condPass = !flags.z; // NE
			4'h2: dec.condPass = flags.c; // CS
			4'h3: dec.condPass = !flags.c; // CC
			4'h4: dec.condPass = flags.n; // MI
			4'h5: dec.condPass = !flags.n; // PL
			4'h6: dec.condPass = flags.v; // VS
			4'h7: dec.condPass = !flags.v; // VC
			4'h8: dec.condPass = flags.c && !flags.z; // HI
			4'h9: dec.condPass = !flags.c || flags.z; // LS
			4'hA: dec.condPass = (flags.n == flags.v); // GE
			4'hB: dec.condPass = (flags.n != flags.v); // LT
			4'hC: dec.condPass = !flags.z && (flags.n == flags.v); // GT
			4'hD: dec.condPass = flags.z || (flags.n != flags.v); // LE
			default: dec.condPass = 1'b1; // AL and unconditional space
		endcase
	end

	assign dec.listCount = 5'($countones(instr[listHi:0]));
	assign listBytes = ldmOffset_t'({dec.listCount, 2'b00});

	// LDM start offset from the P and U bits
	always_comb begin
		case ({instr[bitP], instr[bitU]})
			2'b00: begin // Decrement after
				dec.startOffset = listBytes - ldmOffset_t'(wordBytes);
				dec.addUp = 1'b0;
			end
			2'b01: begin // Increment after
				dec.startOffset = '0;
				dec.addUp = 1'b1;
			end
			2'b10: begin // Decrement before
				dec.startOffset = listBytes;
				dec.addUp = 1'b0;
			end
			default: begin // Increment before
				dec.startOffset = ldmOffset_t'(wordBytes);
				dec.addUp = 1'b1;
			end
		endcase
	end

endmodule

// File: design/uopIfs.sv
// Expander internal buses
`timescale 1ns/10ps

interface decodeIf
	import armIsaPkg::*;
	import uopCtrlPkg::*;
();
	armInstr_t instr; // Held instruction word
	instrClass_t cls;
	logic condPass; // Condition field holds for current flags
	logic addUp; // LDM transfers add their offset
	ldmOffset_t startOffset; // Offset of the first LDM transfer
	logic [4:0] listCount; // Set bits in the register list

	modport src (output instr, cls, condPass, addUp, startOffset, listCount);
	modport dst (input instr, cls, condPass, addUp, startOffset, listCount);
endinterface

interface ldmIf
	import armIsaPkg::*;
	import uopCtrlPkg::*;
();
	armReg_t nextReg; // Lowest pending register
	logic lastReg; // Only one register left
	ldmOffset_t curOffset; // Offset of this transfer
	logic take; // Transfer accepted this cycle

	modport src (
		output nextReg, lastReg, curOffset,
		input take
	);
	modport dst (
		input nextReg, lastReg, curOffset,
		output take
	);
endinterface

// File: design/uopCtrlPkg.sv
// Micro-op control types
package uopCtrlPkg;

	typedef enum logic [2:0] {
		clsPlain,
		clsRsr, // Register-shifted-register data processing
		clsMla, // Multiply-accumulate, short or long
		clsBl, // Branch with link
		clsLdm // Load multiple
	} instrClass_t;

	typedef enum logic [2:0] {
		stReady,
		stRsr,
		stMla,
		stBl,
		stLdm
	} seqState_t;

	typedef struct packed {
		logic firstRead; // Mux on the first read port
		logic wa3; // Write port goes to Rz
		logic ra2; // Second read port goes to Rz
		logic ra1; // First read port goes to Rz
	} rzSel_t;

	localparam rzSel_t rzNone = 4'b0000;
	localparam rzSel_t rzWrite = 4'b1100; // Result into Rz
	localparam rzSel_t rzReadB = 4'b0010;
	localparam rzSel_t rzReadA = 4'b0001;

	typedef logic [11:0] ldmOffset_t; // Immediate offset of one LDM transfer

	typedef struct packed {
		logic instrMux; // Micro-op replaces the fetched word
		logic noFlagUpdate;
		logic uopStall; // More micro-ops follow
		logic ldmForward;
		logic prevRsr;
		logic keepV;
	} uopCtrl_t;

endpackage

// File: design/armIsaPkg.sv
// ARM instruction encoding
package armIsaPkg;

	typedef logic [31:0] armInstr_t; // Instruction or micro-op word
	typedef logic [3:0] armCond_t; // Condition field
	typedef logic [3:0] armReg_t; // Register number
	typedef logic [15:0] regList_t; // LDM register list

	typedef struct packed {
		logic n; // Negative
		logic z; // Zero
		logic c; // Carry
		logic v; // Overflow
	} armFlags_t;

	// Bit positions inside the instruction word
	localparam int condHi = 31;
	localparam int condLo = 28;
	localparam int classHi = 27;
	localparam int classLo = 25;
	localparam int bitP = 24; // Pre-index, also the link bit of B/BL
	localparam int bitU = 23; // Up, also the long bit of multiplies
	localparam int bitB = 22; // Byte, also signed for long multiplies
	localparam int bitA = 21; // Accumulate in multiplies
	localparam int bitSL = 20; // Set flags or load
	localparam int rnHi = 19;
	localparam int rnLo = 16;
	localparam int rdHi = 15;
	localparam int rdLo = 12;
	localparam int rsHi = 11;
	localparam int rsLo = 8;
	localparam int mulHi = 7; // Multiply marker nibble, also bits 7 and 4 of RSR
	localparam int mulLo = 4;
	localparam int listHi = 15; // Top of the LDM register list

	// Opcodes
	localparam logic [3:0] dpMov = 4'b1101;
	localparam logic [3:0] dpAdd = 4'b0100;
	localparam logic [3:0] mulMarker = 4'b1001;
	localparam logic [2:0] lsSingleImm = 3'b010; // Single load/store, immediate offset

	// Register numbers
	localparam armReg_t regLink = 4'd14;
	localparam armReg_t regPc = 4'd15;
	localparam armReg_t regRz = 4'd15; // Extended file entry, picked by regFileRz

	localparam int wordBytes = 4;

endpackage
